/* common/ICachePkg.sv */
// Instruction cache front end shared definitions
// Address field widths and the invalidation sweeper state encoding

`default_nettype none

package ICachePkg;

    // Address layout
    localparam int AddrWidth = 32;
    localparam int PageOffsetWidth = 12;
    localparam int PageNumWidth = AddrWidth - PageOffsetWidth;

    // Sweeper FSM states
    typedef enum logic {
        SweepIdle = 1'b0,
        SweepActive = 1'b1
    } SweepState;

endpackage

`default_nettype wire

/* icache/ICacheSweeper.sv */
// Instruction cache invalidation sweeper
// Collects cache and TLB invalidation requests, then walks every set
// once a sweep is enabled, clearing valid bits and flushing the TLB

`timescale 1ns/1ns
`default_nettype none

module ICacheSweeper #(
    parameter int IndexWidth = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sweepStart,
    input  logic                  invalidateICacheReq,
    input  logic                  invalidateTlbReq,
    output logic                  sweepWrite,
    output logic                  sweepClear,
    output logic                  tlbFlush,
    output logic                  busy,
    output logic                  done,
    output logic                  waitInvalidate,
    output logic [IndexWidth-1:0] sweepIndex
);

    ICachePkg::SweepState state;
    logic [IndexWidth-1:0] setCount;

    // Pending requests
    logic waitCache;
    logic waitTlb;

    // Requests being served by the current sweep
    logic doCache;
    logic doTlb;

    logic lastSet;

    assign lastSet = &setCount;

    assign busy = (state == ICachePkg::SweepActive);
    assign sweepWrite = busy;
    assign sweepIndex = setCount;
    assign sweepClear = doCache;
    assign tlbFlush = doTlb;
    assign done = busy && lastSet;
    assign waitInvalidate = waitCache || waitTlb;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ICachePkg::SweepIdle;
            setCount <= '0;
            waitCache <= 1'b0;
            waitTlb <= 1'b0;
            doCache <= 1'b0;
            doTlb <= 1'b0;
        end else begin
            case (state)
                ICachePkg::SweepIdle: begin
                    if (sweepStart) begin
                        // Pending requests, including one arriving now, move into this sweep
                        state <= ICachePkg::SweepActive;
                        setCount <= '0;
                        doCache <= waitCache || invalidateICacheReq;
                        doTlb <= waitTlb || invalidateTlbReq;
                        waitCache <= 1'b0;
                        waitTlb <= 1'b0;
                    end else begin
                        waitCache <= waitCache || invalidateICacheReq;
                        waitTlb <= waitTlb || invalidateTlbReq;
                    end
                end
                ICachePkg::SweepActive: begin
                    setCount <= setCount + 1'b1;
                    // Held over for the next sweep
                    waitCache <= waitCache || invalidateICacheReq;
                    waitTlb <= waitTlb || invalidateTlbReq;
                    if (lastSet) begin
                        state <= ICachePkg::SweepIdle;
                        doCache <= 1'b0;
                        doTlb <= 1'b0;
                    end
                end
                default: begin
                    state <= ICachePkg::SweepIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* icache/ICacheTagArray.sv */
// Instruction cache tag array
// One valid bit and one physical tag per set, read through a register
// on lookup, written by refills and cleared by the sweeper

`timescale 1ns/1ns
`default_nettype none

module ICacheTagArray #(
    parameter int IndexWidth = 4,
    parameter int TagWidth = 20
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  lookupValid,
    input  logic                  tagFill,
    input  logic                  sweepWrite,
    input  logic                  sweepClear,
    input  logic [IndexWidth-1:0] lookupIndex,
    input  logic [IndexWidth-1:0] fillIndex,
    input  logic [IndexWidth-1:0] sweepIndex,
    input  logic [TagWidth-1:0]   fillTag,
    output logic                  tagValid,
    output logic [TagWidth-1:0]   tagData
);

    localparam int Sets = 2 ** IndexWidth;

    logic [Sets-1:0] validBits;
    logic [TagWidth-1:0] tags [Sets];

    // Sweep wins over refill for the valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
        end else if (sweepWrite) begin
            if (sweepClear) begin
                validBits[sweepIndex] <= 1'b0;
            end
        end else if (tagFill) begin
            validBits[fillIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tagFill && !sweepWrite) begin
            tags[fillIndex] <= fillTag;
        end
    end

    // Registered read
    always_ff @(posedge clk) begin
        if (rst) begin
            tagValid <= 1'b0;
        end else if (lookupValid) begin
            tagValid <= validBits[lookupIndex];
        end
    end

    always_ff @(posedge clk) begin
        if (lookupValid) begin
            tagData <= tags[lookupIndex];
        end
    end

endmodule

`default_nettype wire

/* icache/ICacheItlb.sv */
// Instruction TLB
// Small fully associative table of page translations with a registered
// lookup, round-robin refill and a flush that drops every entry

`timescale 1ns/1ns
`default_nettype none

module ICacheItlb #(
    parameter int TlbEntries = 4
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            lookupValid,
    input  logic                            tlbFill,
    input  logic                            tlbFlush,
    input  logic [ICachePkg::PageNumWidth-1:0] lookupVpn,
    input  logic [ICachePkg::PageNumWidth-1:0] fillVpn,
    input  logic [ICachePkg::PageNumWidth-1:0] fillPpn,
    output logic                            tlbHit,
    output logic [ICachePkg::PageNumWidth-1:0] tlbPpn
);

    localparam int PtrWidth = (TlbEntries > 1) ? $clog2(TlbEntries) : 1;

    logic [TlbEntries-1:0] entryValid;
    logic [ICachePkg::PageNumWidth-1:0] entryVpn [TlbEntries];
    logic [ICachePkg::PageNumWidth-1:0] entryPpn [TlbEntries];
    logic [PtrWidth-1:0] fillPtr;

    logic matchHit;
    logic [ICachePkg::PageNumWidth-1:0] matchPpn;

    // Parallel compare where at most one entry matches
    always_comb begin
        matchHit = 1'b0;
        matchPpn = '0;
        for (int i = 0; i < TlbEntries; i++) begin
            if (entryValid[i] && entryVpn[i] == lookupVpn) begin
                matchHit = 1'b1;
                matchPpn = matchPpn | entryPpn[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
            fillPtr <= '0;
        end else if (tlbFlush) begin
            entryValid <= '0;
        end else if (tlbFill) begin
            entryValid[fillPtr] <= 1'b1;
            // Wrap for entry counts that are not a power of two
            if (fillPtr == PtrWidth'(TlbEntries - 1)) begin
                fillPtr <= '0;
            end else begin
                fillPtr <= fillPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tlbFill && !tlbFlush) begin
            entryVpn[fillPtr] <= fillVpn;
            entryPpn[fillPtr] <= fillPpn;
        end
    end

    // Lookup result register
    always_ff @(posedge clk) begin
        if (rst) begin
            tlbHit <= 1'b0;
        end else if (lookupValid) begin
            tlbHit <= matchHit;
        end
    end

    always_ff @(posedge clk) begin
        if (lookupValid) begin
            tlbPpn <= matchPpn;
        end
    end

endmodule

`default_nettype wire

/* icache/ICacheHitCheck.sv */
// Instruction cache hit check
// Lines up the page offset with the registered TLB and tag results,
// forms the physical address and compares its tag with the stored one

`timescale 1ns/1ns
`default_nettype none

module ICacheHitCheck #(
    parameter int IndexWidth = 4,
    parameter int TagWidth = 24
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  lookupValid,
    input  logic                                  tlbHit,
    input  logic                                  tagValid,
    input  logic [ICachePkg::PageOffsetWidth-1:0] pageOffset,
    input  logic [ICachePkg::PageNumWidth-1:0]    tlbPpn,
    input  logic [TagWidth-1:0]                   tagData,
    output logic                                  resultValid,
    output logic                                  hit,
    output logic                                  tlbMiss,
    output logic [ICachePkg::AddrWidth-1:0]       physAddr
);

    // Tag sits above the line offset and the set index
    localparam int LineOffsetWidth = ICachePkg::AddrWidth - TagWidth - IndexWidth;
    localparam int TagLsb = LineOffsetWidth + IndexWidth;

    logic [ICachePkg::PageOffsetWidth-1:0] offsetReg;
    logic [TagWidth-1:0] physTag;

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= lookupValid;
        end
    end

    always_ff @(posedge clk) begin
        if (lookupValid) begin
            offsetReg <= pageOffset;
        end
    end

    assign physAddr = {tlbPpn, offsetReg};
    assign physTag = physAddr[TagLsb +: TagWidth];

    assign tlbMiss = !tlbHit;
    assign hit = tlbHit && tagValid && (tagData == physTag);

endmodule

`default_nettype wire

/* src/ICacheFrontEnd.sv */
// Instruction fetch front end
// Translates a fetch address through the ITLB, checks it against the
// tag array, and runs invalidation sweeps over both on request

`timescale 1ns/1ns
`default_nettype none

module ICacheFrontEnd #(
    parameter int LineSize = 16,
    parameter int IndexWidth = 4,
    parameter int TlbEntries = 4
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               lookupValid,
    input  logic                               tagFill,
    input  logic                               tlbFill,
    input  logic                               invalidateICacheReq,
    input  logic                               invalidateTlbReq,
    input  logic                               sweepStart,
    input  logic [ICachePkg::AddrWidth-1:0]    lookupAddr,
    input  logic [ICachePkg::AddrWidth-1:0]    fillAddr,
    input  logic [ICachePkg::PageNumWidth-1:0] fillVpn,
    input  logic [ICachePkg::PageNumWidth-1:0] fillPpn,
    output logic                               resultValid,
    output logic                               hit,
    output logic                               tlbMiss,
    output logic                               busy,
    output logic                               done,
    output logic                               waitInvalidate,
    output logic [ICachePkg::AddrWidth-1:0]    physAddr
);

    // Line offset and index must stay inside the page offset
    localparam int IndexLsb = $clog2(LineSize);
    localparam int TagWidth = ICachePkg::AddrWidth - IndexLsb - IndexWidth;

    logic sweepWrite;
    logic sweepClear;
    logic tlbFlush;
    logic [IndexWidth-1:0] sweepIndex;

    logic tlbHit;
    logic [ICachePkg::PageNumWidth-1:0] tlbPpn;
    logic tagValid;
    logic [TagWidth-1:0] tagData;

    ICacheSweeper #(
        .IndexWidth(IndexWidth)
    ) u_sweeper (
        .clk                (clk),
        .rst                (rst),
        .sweepStart         (sweepStart),
        .invalidateICacheReq(invalidateICacheReq),
        .invalidateTlbReq   (invalidateTlbReq),
        .sweepWrite         (sweepWrite),
        .sweepClear         (sweepClear),
        .tlbFlush           (tlbFlush),
        .busy               (busy),
        .done               (done),
        .waitInvalidate     (waitInvalidate),
        .sweepIndex         (sweepIndex)
    );

    ICacheTagArray #(
        .IndexWidth(IndexWidth),
        .TagWidth  (TagWidth)
    ) u_tagArray (
        .clk        (clk),
        .rst        (rst),
        .lookupValid(lookupValid),
        .tagFill    (tagFill),
        .sweepWrite (sweepWrite),
        .sweepClear (sweepClear),
        .lookupIndex(lookupAddr[IndexLsb +: IndexWidth]),
        .fillIndex  (fillAddr[IndexLsb +: IndexWidth]),
        .sweepIndex (sweepIndex),
        .fillTag    (fillAddr[ICachePkg::AddrWidth-1 -: TagWidth]),
        .tagValid   (tagValid),
        .tagData    (tagData)
    );

    ICacheItlb #(
        .TlbEntries(TlbEntries)
    ) u_itlb (
        .clk        (clk),
        .rst        (rst),
        .lookupValid(lookupValid),
        .tlbFill    (tlbFill),
        .tlbFlush   (tlbFlush),
        .lookupVpn  (lookupAddr[ICachePkg::AddrWidth-1 -: ICachePkg::PageNumWidth]),
        .fillVpn    (fillVpn),
        .fillPpn    (fillPpn),
        .tlbHit     (tlbHit),
        .tlbPpn     (tlbPpn)
    );

    ICacheHitCheck #(
        .IndexWidth(IndexWidth),
        .TagWidth  (TagWidth)
    ) u_hitCheck (
        .clk        (clk),
        .rst        (rst),
        .lookupValid(lookupValid),
        .tlbHit     (tlbHit),
        .tagValid   (tagValid),
        .pageOffset (lookupAddr[ICachePkg::PageOffsetWidth-1:0]),
        .tlbPpn     (tlbPpn),
        .tagData    (tagData),
        .resultValid(resultValid),
        .hit        (hit),
        .tlbMiss    (tlbMiss),
        .physAddr   (physAddr)
    );

endmodule

`default_nettype wire

/* testbench/ICacheFrontEndTb.sv */
// Instruction fetch front end testbench
// Directed tests for lookup, refill and invalidation sweeps, checked
// against a small model of the TLB and the tag array

`timescale 1ns/1ns
`default_nettype none

module ICacheFrontEndTb;

    localparam int TlbEntries = 4;
    localparam int Sets = 16;

    logic clk;
    logic rst;
    logic lookupValid, tagFill, tlbFill, invalidateICacheReq, invalidateTlbReq, sweepStart;
    logic [31:0] lookupAddr, fillAddr;
    logic [19:0] fillVpn, fillPpn;
    logic resultValid, hit, tlbMiss, busy, done, waitInvalidate;
    logic [31:0] physAddr;

    // Model of the TLB entries and the per-set tags
    logic [TlbEntries-1:0] modelTlbValid;
    logic [19:0] modelTlbVpn [TlbEntries];
    logic [19:0] modelTlbPpn [TlbEntries];
    int modelPtr;
    logic [Sets-1:0] modelTagValid;
    logic [23:0] modelTag [Sets];

    logic [19:0] pageVpn [5];
    logic [19:0] pagePpn [5];
    logic [11:0] pageOff [5];
    logic [31:0] lookupQueue [$];
    int seed = 20582;
    int passCount;
    int failCount;

    ICacheFrontEnd u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic checkValue(input string testName, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) passCount++;
        else begin
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     testName, what, expected, actual);
            failCount++;
        end
    endtask

    task automatic reportTest(input string testName, input int failsBefore);
        $display("%s finished with %0d failing checks", testName, failCount - failsBefore);
    endtask

    // Returns {tlbHit, hit, physAddr}
    function automatic logic [33:0] predictLookup(input logic [31:0] vaddr);
        logic tHit;
        logic cHit;
        logic [19:0] ppn;
        logic [31:0] paddr;
        tHit = 1'b0;
        ppn = '0;
        for (int i = 0; i < TlbEntries; i++) begin
            if (modelTlbValid[i] && modelTlbVpn[i] == vaddr[31:12]) begin
                tHit = 1'b1;
                ppn = modelTlbPpn[i];
            end
        end
        paddr = {ppn, vaddr[11:0]};
        cHit = tHit && modelTagValid[vaddr[7:4]] && modelTag[vaddr[7:4]] == paddr[31:8];
        return {tHit, cHit, paddr};
    endfunction

    task automatic fillTlb(input logic [19:0] vpn, input logic [19:0] ppn);
        tlbFill = 1'b1;
        fillVpn = vpn;
        fillPpn = ppn;
        @(negedge clk);
        tlbFill = 1'b0;
        modelTlbValid[modelPtr] = 1'b1;
        modelTlbVpn[modelPtr] = vpn;
        modelTlbPpn[modelPtr] = ppn;
        modelPtr = (modelPtr + 1) % TlbEntries;
    endtask

    task automatic fillTag(input logic [31:0] paddr);
        tagFill = 1'b1;
        fillAddr = paddr;
        @(negedge clk);
        tagFill = 1'b0;
        modelTagValid[paddr[7:4]] = 1'b1;
        modelTag[paddr[7:4]] = paddr[31:8];
    endtask

    task automatic makePages(input int count);
        logic [31:0] rnd;
        logic [19:0] base;
        rnd = $random(seed);
        base = rnd[19:0];
        for (int i = 0; i < count; i++) begin
            pageVpn[i] = base + 20'(i);
            rnd = $random(seed);
            pagePpn[i] = rnd[19:0];
            rnd = $random(seed);
            pageOff[i] = rnd[11:0];
        end
    endtask

    task automatic queuePages(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            lookupQueue.push_back({pageVpn[i], pageOff[i]});
        end
    endtask

    task automatic fillPageTags(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            fillTag({pagePpn[i], pageOff[i]});
        end
    endtask

    // Back to back lookups with each result checked one cycle later
    task automatic runLookups(input string testName);
        logic [33:0] expected;
        int count;
        count = lookupQueue.size();
        lookupValid = 1'b1;
        lookupAddr = lookupQueue[0];
        expected = predictLookup(lookupQueue[0]);
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            checkValue(testName, "resultValid", 32'd1, 32'(resultValid));
            checkValue(testName, "tlbMiss", 32'(!expected[33]), 32'(tlbMiss));
            checkValue(testName, "hit", 32'(expected[32]), 32'(hit));
            if (expected[33]) begin
                checkValue(testName, "physAddr", expected[31:0], physAddr);
            end
            if (i + 1 < count) begin
                lookupAddr = lookupQueue[i + 1];
                expected = predictLookup(lookupQueue[i + 1]);
            end else begin
                lookupValid = 1'b0;
            end
        end
        lookupQueue.delete();
    endtask

    task automatic pulseRequest(input string testName, input logic cacheReq, input logic tlbReq);
        invalidateICacheReq = cacheReq;
        invalidateTlbReq = tlbReq;
        @(negedge clk);
        invalidateICacheReq = 1'b0;
        invalidateTlbReq = 1'b0;
        checkValue(testName, "waitInvalidate", 32'd1, 32'(waitInvalidate));
    endtask

    task automatic runSweep(input string testName, input logic clearTags,
                            input logic flushTlb, input logic lateCacheReq);
        ICachePkg::SweepState seen;
        int busyCycles;
        int waited;
        busyCycles = 0;
        waited = 0;
        sweepStart = 1'b1;
        @(negedge clk);
        sweepStart = 1'b0;
        while (!done && waited < 40) begin
            if (busy) busyCycles++;
            // Cache request arriving mid sweep is held for the next one
            invalidateICacheReq = lateCacheReq && busyCycles == 4;
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            seen = busy ? ICachePkg::SweepActive : ICachePkg::SweepIdle;
            $display("%s: no done pulse within 40 cycles, sweeper %s", testName, seen.name());
            failCount++;
        end else begin
            checkValue(testName, "busy cycles", 32'd16, 32'(busyCycles + 1));
            @(negedge clk);
            checkValue(testName, "busy after done", 32'd0, 32'(busy));
            if (clearTags) modelTagValid = '0;
            if (flushTlb) modelTlbValid = '0;
        end
    endtask

    task automatic coldMiss();
        int failsBefore;
        logic [31:0] rnd;
        failsBefore = failCount;
        checkValue("coldMiss", "idle outputs", 32'd0,
                   32'({busy, done, waitInvalidate, resultValid}));
        rnd = $random(seed);
        lookupQueue.push_back(rnd);
        runLookups("coldMiss");
        reportTest("coldMiss", failsBefore);
    endtask

    task automatic translateHit();
        int failsBefore;
        failsBefore = failCount;
        makePages(4);
        for (int i = 0; i < 4; i++) begin
            fillTlb(pageVpn[i], pagePpn[i]);
        end
        fillPageTags(0, 2);
        queuePages(0, 3);
        for (int i = 0; i < 4; i++) begin
            // Other set and then the same set with a different tag
            lookupQueue.push_back({pageVpn[i], pageOff[i] ^ 12'h0f0});
            lookupQueue.push_back({pageVpn[i], pageOff[i] ^ 12'h100});
        end
        lookupQueue.push_back({pageVpn[0] + 20'd9, pageOff[0]});
        runLookups("translateHit");
        reportTest("translateHit", failsBefore);
    endtask

    task automatic roundRobin();
        int failsBefore;
        failsBefore = failCount;
        makePages(5);
        for (int i = 0; i < 5; i++) begin
            fillTlb(pageVpn[i], pagePpn[i]);
        end
        fillPageTags(0, 4);
        queuePages(0, 4);
        runLookups("roundRobin");
        reportTest("roundRobin", failsBefore);
    endtask

    task automatic cacheInvalidate();
        int failsBefore;
        failsBefore = failCount;
        fillPageTags(1, 4);
        queuePages(1, 4);
        runLookups("cacheInvalidate");
        pulseRequest("cacheInvalidate", 1'b1, 1'b0);
        runSweep("cacheInvalidate", 1'b1, 1'b0, 1'b0);
        checkValue("cacheInvalidate", "waitInvalidate", 32'd0, 32'(waitInvalidate));
        queuePages(1, 4);
        runLookups("cacheInvalidate");
        reportTest("cacheInvalidate", failsBefore);
    endtask

    task automatic tlbInvalidate();
        int failsBefore;
        failsBefore = failCount;
        fillPageTags(1, 4);
        pulseRequest("tlbInvalidate", 1'b0, 1'b1);
        runSweep("tlbInvalidate", 1'b0, 1'b1, 1'b1);
        checkValue("tlbInvalidate", "held waitInvalidate", 32'd1, 32'(waitInvalidate));
        queuePages(1, 4);
        runLookups("tlbInvalidate");
        for (int i = 1; i <= 4; i++) begin
            fillTlb(pageVpn[i], pagePpn[i]);
        end
        queuePages(1, 4);
        runLookups("tlbInvalidate");
        // Held cache request is served by this sweep
        runSweep("tlbInvalidate", 1'b1, 1'b0, 1'b0);
        checkValue("tlbInvalidate", "waitInvalidate", 32'd0, 32'(waitInvalidate));
        queuePages(1, 4);
        runLookups("tlbInvalidate");
        reportTest("tlbInvalidate", failsBefore);
    endtask

    initial begin
        rst = 1'b1;
        lookupValid = 1'b0;
        tagFill = 1'b0;
        tlbFill = 1'b0;
        invalidateICacheReq = 1'b0;
        invalidateTlbReq = 1'b0;
        sweepStart = 1'b0;
        lookupAddr = '0;
        fillAddr = '0;
        fillVpn = '0;
        fillPpn = '0;
        passCount = 0;
        failCount = 0;
        modelPtr = 0;
        modelTlbValid = '0;
        modelTagValid = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        coldMiss();
        translateHit();
        roundRobin();
        cacheInvalidate();
        tlbInvalidate();
        $display("Checks passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
common/ICachePkg.sv
icache/ICacheSweeper.sv
icache/ICacheTagArray.sv
icache/ICacheItlb.sv
icache/ICacheHitCheck.sv
src/ICacheFrontEnd.sv
testbench/ICacheFrontEndTb.sv

/* Makefile */
# Verilator build and run for the instruction fetch front end testbench

TOP := ICacheFrontEndTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns --top-module $(TOP) \
		-f all.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
